/* peripheral_subsystem.f */
periph_pkg.sv
periph_bus_bridge.sv
soc_ctrl.sv
intr_ctrl.sv
peripheral_subsystem.sv
tb_peripheral_subsystem.sv

/* Makefile */
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_peripheral_subsystem
FILELIST  ?= peripheral_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_peripheral_subsystem.sv */
/*
 * Directed testbench. Expects one response exactly one cycle after each grant.
 * Run time is bounded by a watchdog sized from the access count.
 */
module tb_peripheral_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  import periph_pkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 3;
  localparam int NUM_ACCESSES   = 64;
  // Three cycles per access plus interrupt waits, doubled for margin
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 3 * NUM_ACCESSES + 40);

  localparam logic [ADDR_W-1:0] EXIT_VALID_A = SOC_CTRL_BASE | ADDR_W'(SOC_EXIT_VALID_OFS);
  localparam logic [ADDR_W-1:0] EXIT_VALUE_A = SOC_CTRL_BASE | ADDR_W'(SOC_EXIT_VALUE_OFS);
  localparam logic [ADDR_W-1:0] SCRATCH_A    = SOC_CTRL_BASE | ADDR_W'(SOC_SCRATCH_OFS);
  localparam logic [ADDR_W-1:0] PENDING_A    = INTR_CTRL_BASE | ADDR_W'(INTR_PENDING_OFS);
  localparam logic [ADDR_W-1:0] ENABLE_A     = INTR_CTRL_BASE | ADDR_W'(INTR_ENABLE_OFS);
  localparam logic [ADDR_W-1:0] CLAIM_A      = INTR_CTRL_BASE | ADDR_W'(INTR_CLAIM_OFS);
  localparam logic [ADDR_W-1:0] MSIP_A       = INTR_CTRL_BASE | ADDR_W'(INTR_MSIP_OFS);

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   req;
  logic                   we;
  logic [ADDR_W-1:0]      addr;
  logic [DATA_W-1:0]      wdata;
  logic [BE_W-1:0]        be;
  logic                   gnt;
  logic                   rvalid;
  logic [DATA_W-1:0]      rdata;
  logic [NUM_EXT_IRQ-1:0] intr_ext;
  logic                   irq;
  logic                   msip;
  logic                   exit_valid;
  logic [DATA_W-1:0]      exit_value;

  logic [31:0]            lcg_state = 32'h2a98_dd0c;
  // Reference copies of the writable SoC registers
  logic [DATA_W-1:0]      scratch_m;
  logic [DATA_W-1:0]      exit_value_m;
  int                     errors = 0;
  int                     accesses = 0;

  peripheral_subsystem dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .we_i         (we),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .be_i         (be),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .intr_ext_i   (intr_ext),
    .irq_o        (irq),
    .msip_o       (msip),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
      input logic [DATA_W-1:0] new_val, input logic [BE_W-1:0] be_mask);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < BE_W; b++) begin
      if (be_mask[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_val,
      input logic [DATA_W-1:0] act_val);
    errors++;
    $display("FAILED t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
  endtask

  // One access with an idle cycle after it
  task automatic bus_access(input logic acc_we, input logic [ADDR_W-1:0] acc_addr,
      input logic [DATA_W-1:0] acc_data, input logic [BE_W-1:0] acc_be,
      output logic [DATA_W-1:0] acc_rdata);
    accesses++;
    @(posedge clk);
    req   <= 1'b1;
    we    <= acc_we;
    addr  <= acc_addr;
    wdata <= acc_data;
    be    <= acc_be;
    @(negedge clk);
    if (gnt !== 1'b1) begin
      errors++;
      $display("No grant for request to %h at t=%0t", acc_addr, $time);
    end
    // The cycle before had no request, so no response may show here
    if (rvalid !== 1'b0) report_mismatch("rvalid_o", '0, DATA_W'(rvalid));
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
    if (rvalid !== 1'b1) begin
      errors++;
      $display("No response in the cycle after request to %h at t=%0t", acc_addr, $time);
    end
    acc_rdata = rdata;
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] acc_addr, input logic [DATA_W-1:0] acc_data,
      input logic [BE_W-1:0] acc_be);
    logic [DATA_W-1:0] unused_rd;
    bus_access(1'b1, acc_addr, acc_data, acc_be, unused_rd);
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] acc_addr, output logic [DATA_W-1:0] acc_rdata);
    bus_access(1'b0, acc_addr, '0, '0, acc_rdata);
  endtask

  // Write and read of the same address in consecutive cycles
  task automatic write_then_read(input logic [ADDR_W-1:0] acc_addr,
      input logic [DATA_W-1:0] acc_data, input logic [BE_W-1:0] acc_be,
      output logic [DATA_W-1:0] acc_rdata);
    accesses += 2;
    @(posedge clk);
    req   <= 1'b1;
    we    <= 1'b1;
    addr  <= acc_addr;
    wdata <= acc_data;
    be    <= acc_be;
    @(posedge clk);
    we <= 1'b0;
    @(negedge clk);
    if (rvalid !== 1'b1 || gnt !== 1'b1) begin
      errors++;
      $display("Back-to-back write got no response or read got no grant at t=%0t", $time);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    if (rvalid !== 1'b1) begin
      errors++;
      $display("Back-to-back read got no response at t=%0t", $time);
    end
    acc_rdata = rdata;
  endtask

  task automatic wait_irq(input logic level, input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (irq !== level && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level) begin
      errors++;
      $display("irq_o did not reach %b within %0d cycles at t=%0t", level, max_cycles, $time);
    end
  endtask

  task automatic check_reset_state();
    logic [DATA_W-1:0] rd;
    @(negedge clk);
    if (irq !== 1'b0) report_mismatch("irq_o", '0, DATA_W'(irq));
    if (msip !== 1'b0) report_mismatch("msip_o", '0, DATA_W'(msip));
    if (exit_valid !== 1'b0) report_mismatch("exit_valid_o", '0, DATA_W'(exit_valid));
    bus_read(SCRATCH_A, rd);
    if (rd !== '0) report_mismatch("scratch", '0, rd);
    bus_read(ENABLE_A, rd);
    if (rd !== '0) report_mismatch("enable", '0, rd);
    bus_read(PENDING_A, rd);
    if (rd !== '0) report_mismatch("pending", '0, rd);
  endtask

  task automatic test_register_rw();
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] rd;
    logic [BE_W-1:0]   mask;
    for (int i = 0; i < 8; i++) begin
      data = next_rand();
      mask = BE_W'(next_rand() >> 13);
      scratch_m = merge_bytes(scratch_m, data, mask);
      write_then_read(SCRATCH_A, data, mask, rd);
      if (rd !== scratch_m) report_mismatch("scratch", scratch_m, rd);
      data = next_rand();
      mask = BE_W'(next_rand() >> 13);
      exit_value_m = merge_bytes(exit_value_m, data, mask);
      bus_write(EXIT_VALUE_A, data, mask);
      bus_read(EXIT_VALUE_A, rd);
      if (rd !== exit_value_m) report_mismatch("exit_value", exit_value_m, rd);
    end
  endtask

  task automatic test_exit_signal();
    logic [DATA_W-1:0] data;
    data = next_rand();
    bus_write(EXIT_VALUE_A, data, 4'hf);
    exit_value_m = data;
    bus_write(EXIT_VALID_A, 32'h1, 4'h1);
    @(negedge clk);
    if (exit_value !== data) report_mismatch("exit_value_o", data, exit_value);
    if (exit_valid !== 1'b1) report_mismatch("exit_valid_o", 32'h1, DATA_W'(exit_valid));
  endtask

  task automatic test_unmapped();
    logic [DATA_W-1:0] rd;
    bus_read(32'h3000_0008, rd);
    if (rd !== UNMAPPED_RDATA) report_mismatch("rdata_o", UNMAPPED_RDATA, rd);
    bus_read(32'h2002_0000, rd);
    if (rd !== UNMAPPED_RDATA) report_mismatch("rdata_o", UNMAPPED_RDATA, rd);
    // Offsets that would hit real registers inside a mapped window
    bus_write(32'h2002_0008, ~scratch_m, 4'hf);
    bus_write(32'h1000_0004, ~exit_value_m, 4'hf);
    bus_write(32'h2003_0004, 32'hffff_ffff, 4'hf);
    bus_write(32'h2004_0000, 32'h0, 4'hf);
    bus_read(SCRATCH_A, rd);
    if (rd !== scratch_m) report_mismatch("scratch", scratch_m, rd);
    bus_read(EXIT_VALUE_A, rd);
    if (rd !== exit_value_m) report_mismatch("exit_value", exit_value_m, rd);
    bus_read(ENABLE_A, rd);
    if (rd !== '0) report_mismatch("enable", '0, rd);
    if (exit_valid !== 1'b1) report_mismatch("exit_valid_o", 32'h1, DATA_W'(exit_valid));
  endtask

  task automatic test_interrupts();
    logic [DATA_W-1:0] rd;
    int                ids[3] = '{5, 9, 12};
    // ID 3 pending but never enabled
    @(posedge clk);
    intr_ext[2] <= 1'b1;
    repeat (6) begin
      @(negedge clk);
      if (irq !== 1'b0) report_mismatch("irq_o", '0, DATA_W'(irq));
    end
    bus_read(PENDING_A, rd);
    if (rd !== 32'h0000_0008) report_mismatch("pending", 32'h0000_0008, rd);
    bus_write(ENABLE_A, 32'h0000_1220, 4'hf);
    @(posedge clk);
    intr_ext[4]  <= 1'b1;
    intr_ext[8]  <= 1'b1;
    intr_ext[11] <= 1'b1;
    wait_irq(1'b1, 4);
    bus_read(PENDING_A, rd);
    if (rd !== 32'h0000_1228) report_mismatch("pending", 32'h0000_1228, rd);
    for (int i = 0; i < 3; i++) begin
      bus_read(CLAIM_A, rd);
      if (rd !== DATA_W'(ids[i])) report_mismatch("claim", DATA_W'(ids[i]), rd);
      bus_write(CLAIM_A, DATA_W'(ids[i]), 4'h1);
    end
    wait_irq(1'b0, 2);
    bus_read(CLAIM_A, rd);
    if (rd !== '0) report_mismatch("claim", '0, rd);
    bus_read(PENDING_A, rd);
    if (rd !== 32'h0000_0008) report_mismatch("pending", 32'h0000_0008, rd);
    if (irq !== 1'b0) report_mismatch("irq_o", '0, DATA_W'(irq));
    @(posedge clk);
    intr_ext <= '0;
  endtask

  task automatic test_msip();
    logic [DATA_W-1:0] rd;
    bus_write(MSIP_A, 32'h1, 4'h1);
    if (msip !== 1'b1) report_mismatch("msip_o", 32'h1, DATA_W'(msip));
    bus_read(MSIP_A, rd);
    if (rd !== 32'h1) report_mismatch("msip", 32'h1, rd);
    bus_write(MSIP_A, 32'h0, 4'h1);
    if (msip !== 1'b0) report_mismatch("msip_o", '0, DATA_W'(msip));
  endtask

  initial begin
    rst_n    <= 1'b0;
    req      <= 1'b0;
    we       <= 1'b0;
    addr     <= '0;
    wdata    <= '0;
    be       <= '0;
    intr_ext <= '0;
    scratch_m    = '0;
    exit_value_m = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();
    test_register_rw();
    test_exit_signal();
    test_unmapped();
    test_interrupts();
    test_msip();
    $display("accesses=%0d errors=%0d", accesses, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule : tb_peripheral_subsystem

/* peripheral_subsystem.sv */
/*
 * Bus bridge with SoC control and interrupt controller behind it.
 * SoC control at 0x2000_0000, interrupt controller at 0x2001_0000.
 */
module peripheral_subsystem (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [periph_pkg::ADDR_W-1:0]       addr_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::BE_W-1:0]         be_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,

  // Interrupts
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0]  intr_ext_i,
  output logic                                irq_o,
  output logic                                msip_o,

  // Exit status
  output logic                                exit_valid_o,
  output logic [periph_pkg::DATA_W-1:0]       exit_value_o
);

  import periph_pkg::*;

  logic                 soc_sel;
  logic                 intr_sel;
  logic                 bus_we;
  logic [REG_OFS_W-1:0] bus_ofs;
  logic [DATA_W-1:0]    bus_wdata;
  logic [BE_W-1:0]      bus_be;
  logic [DATA_W-1:0]    soc_rdata;
  logic [DATA_W-1:0]    intr_rdata;

  periph_bus_bridge bridge0 (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .soc_sel_o    (soc_sel),
    .intr_sel_o   (intr_sel),
    .bus_we_o     (bus_we),
    .bus_ofs_o    (bus_ofs),
    .bus_wdata_o  (bus_wdata),
    .bus_be_o     (bus_be),
    .soc_rdata_i  (soc_rdata),
    .intr_rdata_i (intr_rdata)
  );

  soc_ctrl soc_ctrl0 (
    .clk_i,
    .rst_n_i,
    .sel_i        (soc_sel),
    .we_i         (bus_we),
    .ofs_i        (bus_ofs),
    .wdata_i      (bus_wdata),
    .be_i         (bus_be),
    .rdata_o      (soc_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  intr_ctrl intr_ctrl0 (
    .clk_i,
    .rst_n_i,
    .sel_i        (intr_sel),
    .we_i         (bus_we),
    .ofs_i        (bus_ofs),
    .wdata_i      (bus_wdata),
    .be_i         (bus_be),
    .rdata_o      (intr_rdata),
    .intr_ext_i,
    .irq_o,
    .msip_o
  );

endmodule : peripheral_subsystem

/* intr_ctrl.sv */
/*
 * Single target interrupt controller. Sources are edge triggered, lowest ID wins.
 * A claim read has no side effect. Writing the ID to CLAIM completes it.
 */
module intr_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                sel_i,
  input  logic                                we_i,
  input  logic [periph_pkg::REG_OFS_W-1:0]    ofs_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::BE_W-1:0]         be_i,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  input  logic [periph_pkg::NUM_EXT_IRQ-1:0]  intr_ext_i,
  output logic                                irq_o,
  output logic                                msip_o
);

  import periph_pkg::*;

  logic [REG_OFS_W-1:0]   ofs_word;
  logic                   wr_en;
  logic [NUM_EXT_IRQ-1:0] src_sync_q;
  logic [NUM_EXT_IRQ-1:0] src_prev_q;
  logic [NUM_SRC-1:0]     set_mask;
  logic [NUM_SRC-1:0]     clr_mask;
  logic [NUM_SRC-1:0]     pending_q;
  logic [NUM_SRC-1:0]     enable_q;
  logic [NUM_SRC-1:0]     active;
  logic [SRC_ID_W-1:0]    claim_id;
  logic                   msip_q;
  logic                   irq_q;

  assign ofs_word = {ofs_i[REG_OFS_W-1:2], 2'b00};
  assign wr_en    = sel_i & we_i;

  // Rising edges of the sampled sources, ID 0 never fires
  assign set_mask = {src_sync_q & ~src_prev_q, 1'b0};
  assign active   = pending_q & enable_q;

  always_comb begin
    clr_mask = '0;
    if (wr_en && ofs_word == INTR_CLAIM_OFS && be_i[0]) begin
      clr_mask[wdata_i[SRC_ID_W-1:0]] = 1'b1;
    end
  end

  // Lowest enabled pending ID
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = SRC_ID_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_sync_q <= '0;
      src_prev_q <= '0;
      pending_q  <= '0;
      enable_q   <= '0;
      msip_q     <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      src_sync_q <= intr_ext_i;
      src_prev_q <= src_sync_q;
      // A new edge wins over a complete of the same ID
      pending_q  <= (pending_q & ~clr_mask) | set_mask;
      irq_q      <= |active;
      if (wr_en && ofs_word == INTR_ENABLE_OFS) begin
        for (int i = 1; i < NUM_SRC; i++) begin
          if (be_i[i/8]) begin
            enable_q[i] <= wdata_i[i];
          end
        end
      end
      if (wr_en && ofs_word == INTR_MSIP_OFS && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    case (ofs_word)
      INTR_PENDING_OFS: rdata_o = DATA_W'(pending_q);
      INTR_ENABLE_OFS:  rdata_o = DATA_W'(enable_q);
      INTR_CLAIM_OFS:   rdata_o = DATA_W'(claim_id);
      INTR_MSIP_OFS:    rdata_o = DATA_W'(msip_q);
      default:          rdata_o = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule : intr_ctrl

/* soc_ctrl.sv */
/*
 * Exit status and scratch registers. Writes land at the end of the select cycle.
 * Exit-valid is bit 0 and only byte 0 can write it.
 */
module soc_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                sel_i,
  input  logic                                we_i,
  input  logic [periph_pkg::REG_OFS_W-1:0]    ofs_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::BE_W-1:0]         be_i,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  output logic                                exit_valid_o,
  output logic [periph_pkg::DATA_W-1:0]       exit_value_o
);

  import periph_pkg::*;

  logic [REG_OFS_W-1:0] ofs_word;
  logic                 wr_en;
  logic                 exit_valid_q;
  logic [DATA_W-1:0]    exit_value_q;
  logic [DATA_W-1:0]    scratch_q;

  // Word aligned offset
  assign ofs_word = {ofs_i[REG_OFS_W-1:2], 2'b00};
  assign wr_en    = sel_i & we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      if (ofs_word == SOC_EXIT_VALID_OFS && be_i[0]) begin
        exit_valid_q <= wdata_i[0];
      end
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b] && ofs_word == SOC_EXIT_VALUE_OFS) begin
          exit_value_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (be_i[b] && ofs_word == SOC_SCRATCH_OFS) begin
          scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    case (ofs_word)
      SOC_EXIT_VALID_OFS: rdata_o = {{(DATA_W-1){1'b0}}, exit_valid_q};
      SOC_EXIT_VALUE_OFS: rdata_o = exit_value_q;
      SOC_SCRATCH_OFS:    rdata_o = scratch_q;
      default:            rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

/* periph_bus_bridge.sv */
/*
 * Always grants. Every granted cycle gets one rvalid_o pulse in the next cycle.
 * Registers alias every 16 bytes inside a window. Unmapped writes are dropped.
 */
module periph_bus_bridge (
  input  logic                                clk_i,
  input  logic                                rst_n_i,

  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [periph_pkg::ADDR_W-1:0]       addr_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::BE_W-1:0]         be_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,

  output logic                                soc_sel_o,
  output logic                                intr_sel_o,
  output logic                                bus_we_o,
  output logic [periph_pkg::REG_OFS_W-1:0]    bus_ofs_o,
  output logic [periph_pkg::DATA_W-1:0]       bus_wdata_o,
  output logic [periph_pkg::BE_W-1:0]         bus_be_o,
  input  logic [periph_pkg::DATA_W-1:0]       soc_rdata_i,
  input  logic [periph_pkg::DATA_W-1:0]       intr_rdata_i
);

  import periph_pkg::*;

  logic              soc_hit;
  logic              intr_hit;
  logic [DATA_W-1:0] rdata_d;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  // Window decode
  assign soc_hit  = (addr_i & WINDOW_MASK) == SOC_CTRL_BASE;
  assign intr_hit = (addr_i & WINDOW_MASK) == INTR_CTRL_BASE;

  assign gnt_o      = req_i;
  assign soc_sel_o  = req_i & soc_hit;
  assign intr_sel_o = req_i & intr_hit;

  // Shared request fields for both peripherals
  assign bus_we_o    = we_i;
  assign bus_ofs_o   = addr_i[REG_OFS_W-1:0];
  assign bus_wdata_o = wdata_i;
  assign bus_be_o    = be_i;

  always_comb begin
    if (soc_hit) begin
      rdata_d = soc_rdata_i;
    end else if (intr_hit) begin
      rdata_d = intr_rdata_i;
    end else begin
      rdata_d = UNMAPPED_RDATA;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= req_i;
      // Data only loads on a granted read
      if (req_i && !we_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : periph_bus_bridge

/* periph_pkg.sv */
/*
 * Address map and register layout of the peripheral subsystem.
 * Each window is 64 KiB and holds four word registers.
 */
package periph_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // Byte offset inside a peripheral window
  localparam int unsigned REG_OFS_W = 4;

  // Address map
  localparam logic [ADDR_W-1:0] SOC_CTRL_BASE  = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] INTR_CTRL_BASE = 32'h2001_0000;
  localparam logic [ADDR_W-1:0] WINDOW_MASK    = 32'hffff_0000;

  // SoC control registers
  localparam logic [REG_OFS_W-1:0] SOC_EXIT_VALID_OFS = 4'h0;
  localparam logic [REG_OFS_W-1:0] SOC_EXIT_VALUE_OFS = 4'h4;
  localparam logic [REG_OFS_W-1:0] SOC_SCRATCH_OFS    = 4'h8;

  // Interrupt controller registers
  localparam logic [REG_OFS_W-1:0] INTR_PENDING_OFS = 4'h0;
  localparam logic [REG_OFS_W-1:0] INTR_ENABLE_OFS  = 4'h4;
  localparam logic [REG_OFS_W-1:0] INTR_CLAIM_OFS   = 4'h8;
  localparam logic [REG_OFS_W-1:0] INTR_MSIP_OFS    = 4'hc;

  // Interrupt IDs, ID 0 means no interrupt
  localparam int unsigned NUM_SRC     = 16;
  localparam int unsigned NUM_EXT_IRQ = NUM_SRC - 1;
  localparam int unsigned SRC_ID_W    = $clog2(NUM_SRC);

  // Returned for reads outside both windows
  localparam logic [DATA_W-1:0] UNMAPPED_RDATA = 32'hdead_beef;

endpackage : periph_pkg
